/* source/core_pkg.sv */
// Core shared types and constants
package core_pkg;

  // Widths with a meaning
  typedef logic [31:0] word_t;      // Data or address word
  typedef logic [4:0]  reg_addr_t;  // Register index
  typedef logic [6:0]  opcode_t;    // Major opcode field
  typedef logic [2:0]  alu_sel_t;   // ALU operation select

  // Major opcodes accepted by the core
  localparam opcode_t OPC_OP_IMM = 7'b0010011;  // addi slti xori ori andi
  localparam opcode_t OPC_OP     = 7'b0110011;  // add sub
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;  // Only ebreak is legal

  // ALU operations
  localparam alu_sel_t ALU_ADD    = 3'd0;  // Also address math for jumps
  localparam alu_sel_t ALU_SUB    = 3'd1;
  localparam alu_sel_t ALU_SLT    = 3'd2;  // Signed compare
  localparam alu_sel_t ALU_XOR    = 3'd3;
  localparam alu_sel_t ALU_OR     = 3'd4;
  localparam alu_sel_t ALU_AND    = 3'd5;
  localparam alu_sel_t ALU_PASS_B = 3'd6;  // Operand B straight through for lui

  // Execute unit state
  typedef enum logic {
    ST_RUN  = 1'b0,  // Fetching and committing
    ST_HALT = 1'b1   // Stopped until reset
  } run_state_e;

endpackage

/* source/dec_if.sv */
// Decode to execute bundle
`timescale 1ns/1ps

interface dec_if;
  import core_pkg::*;

  alu_sel_t  alu_sel;    // ALU operation
  logic      use_imm;    // Operand B is the immediate
  logic      use_pc;     // Operand A is the pc
  word_t     imm;        // Sign extended immediate
  reg_addr_t rd;         // Destination register
  logic      wen;        // Register write, already low for rd zero
  logic      is_jal;
  logic      is_jalr;
  logic      is_ebreak;
  logic      illegal;    // Encoding outside the subset

  // Decode side
  modport src (
    output alu_sel, use_imm, use_pc, imm, rd, wen,
    output is_jal, is_jalr, is_ebreak, illegal
  );

  // Execute side
  modport snk (
    input alu_sel, use_imm, use_pc, imm, rd, wen,
    input is_jal, is_jalr, is_ebreak, illegal
  );

endinterface

/* source/rf_if.sv */
// Register file port bundle
`timescale 1ns/1ps

interface rf_if;
  import core_pkg::*;

  reg_addr_t raddr1;  // rs1 index
  reg_addr_t raddr2;  // rs2 index
  word_t     rdata1;
  word_t     rdata2;
  reg_addr_t waddr;
  word_t     wdata;
  logic      wen;

  modport rd_addr (output raddr1, raddr2);  // Decode picks the sources
  modport rf (input raddr1, raddr2, waddr, wdata, wen, output rdata1, rdata2);
  modport ex (input rdata1, rdata2, output waddr, wdata, wen);

endinterface

/* source/reg_file.sv */
// General purpose register file
`timescale 1ns/1ps

module reg_file (
  input logic clk,
  input logic arst_n,
  rf_if.rf    rf
);
  import core_pkg::*;

  word_t regs [1:31];  // x0 has no storage

  // Write port
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;  // All registers start at zero
      end
    end else if (rf.wen) begin
      regs[rf.waddr] <= rf.wdata;  // Decode never asks for x0
    end
  end

  // Read ports see the value before this cycle's write
  always_comb begin
    if (rf.raddr1 == '0) begin
      rf.rdata1 = '0;  // x0 reads as zero
    end else begin
      rf.rdata1 = regs[rf.raddr1];
    end
  end

  always_comb begin
    if (rf.raddr2 == '0) begin
      rf.rdata2 = '0;
    end else begin
      rf.rdata2 = regs[rf.raddr2];
    end
  end

  // Decode masks writes to x0 so none reach here
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (!arst_n)
    rf.wen |-> (rf.waddr != '0)
  ) else $error("write to x0 reached the register file");

endmodule

/* source/inst_decode.sv */
// Instruction decode unit
`timescale 1ns/1ps

module inst_decode (
  input  core_pkg::word_t inst,
  dec_if.src              dec,
  rf_if.rd_addr           rf
);
  import core_pkg::*;

  localparam word_t EBREAK_WORD = 32'h0010_0073;  // Only legal system encoding

  // Raw fields
  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  reg_addr_t   rd;
  reg_addr_t   rs1;
  reg_addr_t   rs2;

  // Immediate formats
  word_t       imm_i;
  word_t       imm_u;
  word_t       imm_j;

  // Decoded controls before the x0 mask
  alu_sel_t    alu_sel;
  logic        use_imm;
  logic        use_pc;
  word_t       imm;
  logic        wr_req;
  logic        is_jal;
  logic        is_jalr;
  logic        is_ebreak;
  logic        illegal;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // Sources go straight to the register file
  assign rf.raddr1 = rs1;
  assign rf.raddr2 = rs2;

  always_comb begin
    alu_sel   = ALU_ADD;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    imm       = '0;
    wr_req    = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_ebreak = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        imm     = imm_i;
        wr_req  = 1'b1;
        case (funct3)
          3'b000:  alu_sel = ALU_ADD;  // addi
          3'b010:  alu_sel = ALU_SLT;  // slti
          3'b100:  alu_sel = ALU_XOR;  // xori
          3'b110:  alu_sel = ALU_OR;   // ori
          3'b111:  alu_sel = ALU_AND;  // andi
          default: illegal = 1'b1;     // Shifts and sltiu not supported
        endcase
      end
      OPC_OP: begin
        wr_req = 1'b1;
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          alu_sel = ALU_ADD;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
          alu_sel = ALU_SUB;
        end else begin
          illegal = 1'b1;  // Only add and sub here
        end
      end
      OPC_LUI: begin
        use_imm = 1'b1;
        imm     = imm_u;
        alu_sel = ALU_PASS_B;
        wr_req  = 1'b1;
      end
      OPC_AUIPC: begin
        use_pc  = 1'b1;  // pc plus upper immediate
        use_imm = 1'b1;
        imm     = imm_u;
        wr_req  = 1'b1;
      end
      OPC_JAL: begin
        use_pc  = 1'b1;  // ALU forms the target
        use_imm = 1'b1;
        imm     = imm_j;
        wr_req  = 1'b1;
        is_jal  = 1'b1;
      end
      OPC_JALR: begin
        use_imm = 1'b1;  // rs1 plus offset
        imm     = imm_i;
        wr_req  = 1'b1;
        if (funct3 == 3'b000) begin
          is_jalr = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OPC_SYSTEM: begin
        if (inst == EBREAK_WORD) begin
          is_ebreak = 1'b1;
        end else begin
          illegal = 1'b1;  // ecall and CSRs
        end
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      wr_req = 1'b0;  // Trapping instruction never writes
    end
  end

  assign dec.alu_sel   = alu_sel;
  assign dec.use_imm   = use_imm;
  assign dec.use_pc    = use_pc;
  assign dec.imm       = imm;
  assign dec.rd        = rd;
  assign dec.wen       = wr_req && (rd != '0);  // x0 writes dropped here only
  assign dec.is_jal    = is_jal;
  assign dec.is_jalr   = is_jalr;
  assign dec.is_ebreak = is_ebreak;
  assign dec.illegal   = illegal;

  // Execute relies on these classes being exclusive
  always_comb begin
    a_one_class: assert final ($onehot0({is_jal, is_jalr, is_ebreak, illegal}))
      else $error("decode raised more than one instruction class");
  end

endmodule

/* source/exec_unit.sv */
// Execute unit and pc control
`timescale 1ns/1ps

module exec_unit #(
  parameter core_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  logic            clk,
  input  logic            arst_n,
  dec_if.snk              dec,
  rf_if.ex                rf,
  output core_pkg::word_t pc,
  output logic            halt,
  output logic            trap
);
  import core_pkg::*;

  run_state_e state;
  run_state_e state_nxt;

  word_t op_a;       // ALU operand A
  word_t op_b;       // ALU operand B
  word_t alu_res;
  word_t pc_plus4;   // Sequential pc and link value
  word_t jmp_tgt;
  word_t pc_nxt;
  logic  is_jump;
  logic  stop;       // Instruction ends the run
  logic  run;

  assign run      = (state == ST_RUN);
  assign is_jump  = dec.is_jal || dec.is_jalr;
  assign stop     = dec.is_ebreak || dec.illegal;
  assign pc_plus4 = pc + 32'd4;

  // Operand select
  assign op_a = dec.use_pc  ? pc      : rf.rdata1;
  assign op_b = dec.use_imm ? dec.imm : rf.rdata2;

  always_comb begin
    case (dec.alu_sel)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_PASS_B: alu_res = op_b;   // lui
      default:    alu_res = '0;     // Unused code
    endcase
  end

  // jalr drops bit 0 of the sum
  assign jmp_tgt = dec.is_jalr ? {alu_res[31:1], 1'b0} : alu_res;

  // Next pc and next state
  always_comb begin
    pc_nxt    = pc;      // Hold by default
    state_nxt = state;
    if (run) begin
      if (stop) begin
        state_nxt = ST_HALT;  // pc stays on the halting instruction
      end else if (is_jump) begin
        pc_nxt = jmp_tgt;
      end else begin
        pc_nxt = pc_plus4;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc    <= RESET_PC;
      state <= ST_RUN;
      trap  <= 1'b0;
    end else begin
      pc    <= pc_nxt;
      state <= state_nxt;
      if (run && stop) begin
        trap <= dec.illegal;  // Set once at the halting edge
      end
    end
  end

  assign halt = (state == ST_HALT);

  // Write-back
  assign rf.waddr = dec.rd;
  assign rf.wdata = is_jump ? pc_plus4 : alu_res;
  assign rf.wen   = dec.wen && run && !stop && arst_n;  // Silent in reset

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!arst_n)
    pc[1:0] == 2'b00
  ) else $error("pc not word aligned");

  a_pc_frozen: assert property (
    @(posedge clk) disable iff (!arst_n)
    halt |=> $stable(pc)
  ) else $error("pc moved while halted");

endmodule

/* source/core_top.sv */
// Single cycle RV32I core top
`timescale 1ns/1ps

module core_top #(
  parameter core_pkg::word_t RESET_PC = 32'h8000_0000
) (
  input  logic                clk,
  input  logic                arst_n,
  input  core_pkg::word_t     inst,     // Word at pc from outside
  output core_pkg::word_t     pc,       // Fetch address
  output logic                wb_en,    // Write committing at next edge
  output core_pkg::reg_addr_t wb_addr,
  output core_pkg::word_t     wb_data,
  output logic                halt,
  output logic                trap      // Halted on an illegal encoding
);

  dec_if dec_bus ();  // Decode to execute
  rf_if  rf_bus ();   // Register file ports

  inst_decode decode_i (
    .inst (inst),
    .dec  (dec_bus.src),
    .rf   (rf_bus.rd_addr)
  );

  exec_unit #(
    .RESET_PC (RESET_PC)
  ) exec_i (
    .clk    (clk),
    .arst_n (arst_n),
    .dec    (dec_bus.snk),
    .rf     (rf_bus.ex),
    .pc     (pc),
    .halt   (halt),
    .trap   (trap)
  );

  reg_file rf_i (
    .clk    (clk),
    .arst_n (arst_n),
    .rf     (rf_bus.rf)
  );

  // Write port shown at the top for observation
  assign wb_en   = rf_bus.wen;
  assign wb_addr = rf_bus.waddr;
  assign wb_data = rf_bus.wdata;

endmodule

/* sim/core_model.svh */
// Core reference model
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

  word_t     model_regs [0:31];  // x0 never written
  word_t     model_pc;
  logic      model_halted;
  logic      model_trap;
  logic      exp_wen;            // Expected write for the shown instruction
  reg_addr_t exp_addr;
  word_t     exp_data;
  word_t     exp_npc;            // Expected pc after the edge
  logic      exp_stop;
  logic      exp_illegal;

  task automatic model_reset();
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    model_pc     = RESET_PC;
    model_halted = 1'b0;
    model_trap   = 1'b0;
  endtask

  // ISA result of one instruction on the model state
  task automatic predict(input word_t ins);
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_j;
    logic [2:0] f3;
    logic [6:0] f7;
    f3          = ins[14:12];
    f7          = ins[31:25];
    a           = model_regs[ins[19:15]];
    b           = model_regs[ins[24:20]];
    imm_i       = {{20{ins[31]}}, ins[31:20]};
    imm_u       = {ins[31:12], 12'h000};
    imm_j       = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    exp_addr    = ins[11:7];
    exp_wen     = 1'b1;
    exp_data    = '0;
    exp_npc     = model_pc + 32'd4;  // Sequential unless a jump
    exp_stop    = 1'b0;
    exp_illegal = 1'b0;
    case (ins[6:0])
      OPC_OP_IMM: begin
        case (f3)
          3'b000:  exp_data = a + imm_i;
          3'b010:  exp_data = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
          3'b100:  exp_data = a ^ imm_i;
          3'b110:  exp_data = a | imm_i;
          3'b111:  exp_data = a & imm_i;
          default: exp_illegal = 1'b1;  // Shifts, sltiu
        endcase
      end
      OPC_OP: begin
        if (f3 == 3'b000 && f7 == 7'h00) exp_data = a + b;
        else if (f3 == 3'b000 && f7 == 7'h20) exp_data = a - b;
        else exp_illegal = 1'b1;
      end
      OPC_LUI:   exp_data = imm_u;
      OPC_AUIPC: exp_data = model_pc + imm_u;
      OPC_JAL: begin
        exp_data = model_pc + 32'd4;  // Link
        exp_npc  = model_pc + imm_j;
      end
      OPC_JALR: begin
        exp_data = model_pc + 32'd4;
        exp_npc  = (a + imm_i) & ~32'd1;  // Low bit dropped
        if (f3 != 3'b000) exp_illegal = 1'b1;
      end
      OPC_SYSTEM: begin
        if (ins == 32'h0010_0073) exp_stop = 1'b1;  // ebreak
        else exp_illegal = 1'b1;
      end
      default: exp_illegal = 1'b1;
    endcase
    if (exp_illegal) exp_stop = 1'b1;
    if (exp_stop || exp_addr == '0 || model_halted) exp_wen = 1'b0;
    if (exp_stop || model_halted) exp_npc = model_pc;  // Frozen
    if (model_halted) begin
      exp_stop    = 1'b0;  // Already stopped
      exp_illegal = 1'b0;
    end
  endtask

  task automatic model_commit();
    if (exp_wen) model_regs[exp_addr] = exp_data;
    if (exp_stop) begin
      model_halted = 1'b1;
      model_trap   = exp_illegal;
    end
    model_pc = exp_npc;
  endtask

  // Random legal subset instruction
  function automatic word_t gen_legal();
    word_t      w;
    logic [1:0] low;
    w = $random(seed);  // All fields random first
    if (($random(seed) & 15) == 0) w[11:7] = '0;  // More rd zero cases
    case ($unsigned($random(seed)) % 10)
      0, 1, 2, 3: begin
        w[6:0] = OPC_OP_IMM;
        case ($unsigned($random(seed)) % 5)
          0:       w[14:12] = 3'b000;  // addi
          1:       w[14:12] = 3'b010;  // slti
          2:       w[14:12] = 3'b100;  // xori
          3:       w[14:12] = 3'b110;  // ori
          default: w[14:12] = 3'b111;  // andi
        endcase
      end
      4, 5: begin
        w[6:0]   = OPC_OP;
        w[14:12] = 3'b000;
        w[31:25] = w[30] ? 7'b0100000 : 7'b0000000;  // sub or add
      end
      6: w[6:0] = OPC_LUI;
      7: w[6:0] = OPC_AUIPC;
      8: begin
        w[6:0] = OPC_JAL;
        w[21]  = 1'b0;  // Offset bit 1 clear, target stays aligned
      end
      default: begin
        w[6:0]   = OPC_JALR;
        w[14:12] = 3'b000;
        low      = {1'b0, w[22]} - model_regs[w[19:15]][1:0];
        w[21:20] = low;  // Sum ends in 00 or 01
      end
    endcase
    return w;
  endfunction

  function automatic word_t gen_illegal();
    word_t w;
    w = $random(seed);
    case ($unsigned($random(seed)) % 3)
      0:       w[6:0] = 7'b0000011;  // Load
      1:       w[6:0] = 7'b0100011;  // Store
      default: w[6:0] = 7'b1100011;  // Branch
    endcase
    return w;
  endfunction

`endif

/* sim/core_tb.sv */
// Core testbench
`timescale 1ns/1ps

module core_tb;
  import core_pkg::*;

  localparam word_t RESET_PC   = 32'h8000_0000;
  localparam int    RUN_LEN    = 2000;
  localparam int    HALT_LIMIT = 10;            // Cycles allowed for halt
  localparam word_t EBREAK     = 32'h0010_0073;
  localparam word_t NOP        = 32'h0000_0013;  // addi x0, x0, 0
  localparam word_t ADDI_X1    = 32'h0010_0093;  // addi x1, x0, 1

  logic      clk;
  logic      arst_n;
  word_t     inst;
  word_t     pc;
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;
  logic      halt;
  logic      trap;
  integer    seed;

  `include "core_model.svh"

  core_top #(
    .RESET_PC (RESET_PC)
  ) dut_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .inst    (inst),
    .pc      (pc),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .halt    (halt),
    .trap    (trap)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic value_error(input string msg);
    stop_run($sformatf("error at %0t: %s", $time, msg));
  endtask

  task automatic check_reset_state();
    assert (pc === RESET_PC) else value_error($sformatf("pc %h in reset", pc));
    assert (halt === 1'b0 && trap === 1'b0) else value_error("halt or trap high in reset");
    assert (wb_en === 1'b0) else value_error("wb_en high in reset");
  endtask

  task automatic apply_reset();
    arst_n = 1'b0;
    inst   = ADDI_X1;  // A write that reset must hold back
    model_reset();
    repeat (5) begin
      @(posedge clk);
      #1;
      check_reset_state();
    end
    inst   = NOP;
    arst_n = 1'b1;  // Mid cycle release
    #1;
    check_reset_state();
  endtask

  // Compare state, show one instruction, compare the write and commit
  task automatic step(input word_t ins);
    assert (pc === model_pc)
      else value_error($sformatf("pc %h, expected %h", pc, model_pc));
    assert (halt === model_halted && trap === model_trap)
      else value_error($sformatf("halt %b trap %b, expected %b %b",
                                 halt, trap, model_halted, model_trap));
    inst = ins;
    #1;
    predict(ins);
    assert (wb_en === exp_wen)
      else value_error($sformatf("wb_en %b, expected %b, inst %h", wb_en, exp_wen, ins));
    if (exp_wen) begin
      assert (wb_addr === exp_addr && wb_data === exp_data)
        else value_error($sformatf("write x%0d=%h, expected x%0d=%h, inst %h",
                                   wb_addr, wb_data, exp_addr, exp_data, ins));
    end
    model_commit();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_for_halt(output int extra);
    extra = 0;
    while (halt !== 1'b1) begin
      if (extra >= HALT_LIMIT) stop_run("timeout: halt never went high");
      @(posedge clk);
      #1;
      extra++;
    end
  endtask

  initial begin
    word_t halt_pc;
    int    extra;
    seed   = 32'h35f784f3;
    arst_n = 1'b0;
    inst   = NOP;
    apply_reset();
    for (int i = 0; i < RUN_LEN; i++) begin
      step(gen_legal());
    end
    halt_pc = model_pc;
    step(EBREAK);
    wait_for_halt(extra);
    assert (extra == 0) else value_error("halt late after ebreak");
    assert (trap === 1'b0) else value_error("trap high after ebreak");
    repeat (20) step(gen_legal());  // Still shown but never committed
    assert (pc === halt_pc) else value_error("pc moved after ebreak");
    // Second run ends on an illegal opcode
    apply_reset();
    repeat (10) step(gen_legal());
    halt_pc = model_pc;
    step(gen_illegal());
    wait_for_halt(extra);
    assert (extra == 0 && trap === 1'b1) else value_error("no trap halt after illegal");
    repeat (5) step(gen_legal());
    assert (pc === halt_pc) else value_error("pc moved after trap");
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+sim
source/core_pkg.sv
source/dec_if.sv
source/rf_if.sv
source/reg_file.sv
source/inst_decode.sv
source/exec_unit.sv
source/core_top.sv
sim/core_tb.sv
